// File: Makefile
sources := $(shell grep -v '^+' aes_core.f) bench/aes_model.svh

.PHONY: run clean

obj_dir/Vaes_core_tb: aes_core.f $(sources)
	verilator --binary -f aes_core.f --top-module aes_core_tb -o Vaes_core_tb

run: obj_dir/Vaes_core_tb
	@out="$$(./obj_dir/Vaes_core_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir

// File: aes_core.f
+incdir+bench
logic/aes_params_pkg.sv
logic/aes_ops_pkg.sv
logic/key_schedule.sv
logic/cipher.sv
logic/aes_core.sv
bench/aes_core_tb.sv

// File: bench/aes_model.svh
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

// Right-shift Galois LFSR, polynomial x^32 + x^22 + x^2 + x + 1.
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// Shift-and-add product in GF(2^8).
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
	logic [7:0] p;
	logic [7:0] x;
	p = 8'h00;
	x = a;
	for (int i = 0; i < 8; i++) begin
		if (b[i])
			p = p ^ x;
		x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
	end
	return p;
endfunction

// Multiplicative inverse as a^254, then the affine map.
function automatic logic [7:0] sbox_value(input logic [7:0] a);
	logic [7:0] inv;
	logic [7:0] e;
	inv = 8'h01;
	e = 8'hfe;
	for (int i = 7; i >= 0; i--) begin
		inv = gf_mul(inv, inv);
		if (e[i])
			inv = gf_mul(inv, a);
	end
	return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
		^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

// Full key expansion up front, state kept as [row][col].
function automatic logic [127:0] encrypt_ref(input logic [127:0] pt, input logic [127:0] k);
	logic [31:0] w [0:43];
	logic [7:0] s [0:3][0:3];
	logic [7:0] t [0:3][0:3];
	logic [7:0] rc;
	logic [31:0] tmp;
	logic [127:0] out;
	rc = 8'h01;
	for (int i = 0; i < 4; i++)
		w[i] = k[127-32*i -: 32];
	for (int i = 4; i < 44; i++) begin
		tmp = w[i-1];
		if (i % 4 == 0) begin
			tmp = {sbox_value(tmp[23:16]), sbox_value(tmp[15:8]),
				sbox_value(tmp[7:0]), sbox_value(tmp[31:24])} ^ {rc, 24'h000000};
			rc = gf_mul(rc, 8'h02);
		end
		w[i] = w[i-4] ^ tmp;
	end
	for (int c = 0; c < 4; c++)
		for (int r = 0; r < 4; r++)
			s[r][c] = pt[127-8*(4*c+r) -: 8] ^ w[c][31-8*r -: 8];
	for (int rnd = 1; rnd <= 10; rnd++) begin
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < 4; c++)
				t[r][c] = sbox_value(s[r][(c + r) % 4]); // Substitute and shift.
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				if (rnd < 10)
					s[r][c] = gf_mul(t[r][c], 8'h02) ^ gf_mul(t[(r+1)%4][c], 8'h03)
						^ t[(r+2)%4][c] ^ t[(r+3)%4][c];
				else
					s[r][c] = t[r][c];
				s[r][c] = s[r][c] ^ w[4*rnd+c][31-8*r -: 8];
			end
		end
	end
	for (int c = 0; c < 4; c++)
		for (int r = 0; r < 4; r++)
			out[127-8*(4*c+r) -: 8] = s[r][c];
	return out;
endfunction

`endif

// File: bench/aes_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module aes_core_tb;

	`include "aes_model.svh"

	localparam int n_random = 200;
	localparam int n_junk = 20;
	localparam int n_chain = 40;
	localparam int n_blocks = 2 + n_random + 4 + n_junk + n_chain + 2;
	localparam int limit_cycles = n_blocks * 20 + 200;

	logic clk = 1'b0;
	logic reset;
	logic start;
	logic [127:0] plaintext;
	logic [127:0] key;
	logic [127:0] ciphertext;
	logic done;
	logic busy;
	logic [31:0] lfsr = 32'h5c29;
	int errors = 0;
	int errors_at_start = 0;
	int pass_count = 0;
	int fail_count = 0;
	string test_name;

	aes_core i_aes_core (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.plaintext  (plaintext),
		.key        (key),
		.ciphertext (ciphertext),
		.done       (done),
		.busy       (busy)
	);

	always #4 clk = ~clk;

	function automatic logic [127:0] rand_bits(input int n);
		logic [127:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[126:0], lfsr[0]};
			lfsr = lfsr_step(lfsr); // One step per bit.
		end
		return r;
	endfunction

	task automatic check(input logic [127:0] got, input logic [127:0] exp, input string msg);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1; // Drive and sample just after the edge.
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		if (errors == errors_at_start) begin
			pass_count++;
			$display("Test %s: passed", test_name);
		end else begin
			fail_count++;
			$display("Test %s: failed with %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	// Returns in the cycle where done is high.
	task automatic run_block(input logic [127:0] pt, input logic [127:0] k,
		input logic [127:0] exp, input bit junk);
		int edges;
		start = 1'b1;
		plaintext = pt;
		key = k;
		next_cycle();
		start = 1'b0;
		plaintext = rand_bits(128); // Inputs only count while start is high.
		key = rand_bits(128);
		edges = 0;
		while (!done && edges < 20) begin
			check(128'(busy), 128'd1, "busy during a block");
			if (junk) begin
				start = 1'b1;
				plaintext = rand_bits(128);
				key = rand_bits(128);
			end
			next_cycle();
			edges++;
		end
		start = 1'b0;
		if (!done) begin
			$display("Error at %0t: done did not appear within 20 cycles of start", $time);
			errors++;
		end else begin
			check(128'(edges), 128'd11, "edges from start to done");
			check(128'(busy), 128'd0, "busy after the last round");
			check(ciphertext, exp, "ciphertext");
		end
	endtask

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			next_cycle();
			check(128'(done), 128'd0, "done while idle");
			check(128'(busy), 128'd0, "busy while idle");
		end
	endtask

	initial begin
		repeat (limit_cycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles.", limit_cycles);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		logic [127:0] pt;
		logic [127:0] k;
		int gap;
		reset = 1'b1;
		start = 1'b0;
		plaintext = '0;
		key = '0;
		repeat (10) next_cycle();
		reset = 1'b0;

		begin_test("idle after reset");
		check(128'(done), 128'd0, "done after reset");
		check(128'(busy), 128'd0, "busy after reset");
		idle_cycles(5);
		end_test();

		begin_test("known answers");
		pt = 128'h3243f6a8885a308d313198a2e0370734;
		k = 128'h2b7e151628aed2a6abf7158809cf4f3c;
		check(encrypt_ref(pt, k), 128'h3925841d02dc09fbdc118597196a0b32, "model, vector B");
		run_block(pt, k, 128'h3925841d02dc09fbdc118597196a0b32, 1'b0);
		idle_cycles(2);
		pt = 128'h00112233445566778899aabbccddeeff;
		k = 128'h000102030405060708090a0b0c0d0e0f;
		check(encrypt_ref(pt, k), 128'h69c4e0d86a7b0430d8cdb78070b4c55a, "model, vector C.1");
		run_block(pt, k, 128'h69c4e0d86a7b0430d8cdb78070b4c55a, 1'b0);
		idle_cycles(2);
		end_test();

		begin_test("random blocks");
		for (int i = 0; i < n_random; i++) begin
			pt = rand_bits(128);
			k = rand_bits(128);
			run_block(pt, k, encrypt_ref(pt, k), 1'b0);
			idle_cycles(1);
		end
		end_test();

		begin_test("latency");
		for (int i = 0; i < 4; i++) begin
			pt = rand_bits(128);
			k = rand_bits(128);
			run_block(pt, k, encrypt_ref(pt, k), 1'b0); // Counts edges to done.
			idle_cycles(2);
		end
		end_test();

		begin_test("start while busy");
		for (int i = 0; i < n_junk; i++) begin
			pt = rand_bits(128);
			k = rand_bits(128);
			run_block(pt, k, encrypt_ref(pt, k), 1'b1);
			idle_cycles(3); // No second done.
		end
		end_test();

		begin_test("back to back");
		for (int i = 0; i < n_chain; i++) begin
			pt = rand_bits(128);
			k = rand_bits(128);
			run_block(pt, k, encrypt_ref(pt, k), 1'b0);
			gap = int'(rand_bits(3));
			if (i % 2 == 0)
				gap = 0; // Restart in the done cycle.
			idle_cycles(gap);
		end
		idle_cycles(1);
		end_test();

		begin_test("reset during a block");
		start = 1'b1;
		plaintext = rand_bits(128);
		key = rand_bits(128);
		next_cycle();
		start = 1'b0;
		repeat (4) next_cycle();
		reset = 1'b1;
		// Block is aborted at the first reset edge.
		for (int i = 0; i < 10; i++) begin
			next_cycle();
			check(128'(done), 128'd0, "done during reset");
			check(128'(busy), 128'd0, "busy during reset");
		end
		reset = 1'b0;
		check(128'(done), 128'd0, "done after reset");
		check(128'(busy), 128'd0, "busy after reset");
		idle_cycles(15);
		pt = rand_bits(128);
		k = rand_bits(128);
		run_block(pt, k, encrypt_ref(pt, k), 1'b0);
		idle_cycles(2);
		end_test();

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/aes_core.sv
`timescale 1ns/1ps
`default_nettype none

module aes_core (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             start,
	input  logic [aes_params_pkg::blk_s-1:0] plaintext,
	input  logic [aes_params_pkg::key_s-1:0] key,
	output logic [aes_params_pkg::blk_s-1:0] ciphertext,
	output logic                             done,
	output logic                             busy
);
	import aes_params_pkg::*;

	logic [key_s-1:0] round_key;
	logic [round_w-1:0] round_no;
	logic key_valid;

	// Expands the key, one round key per cycle.
	key_schedule i_key_schedule (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.key       (key),
		.round_key (round_key),
		.round_no  (round_no),
		.key_valid (key_valid),
		.busy      (busy)
	);

	cipher i_cipher (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.plaintext  (plaintext),
		.round_key  (round_key),
		.round_no   (round_no),
		.key_valid  (key_valid),
		.ciphertext (ciphertext),
		.done       (done)
	);

endmodule

`default_nettype wire

// File: logic/aes_ops_pkg.sv
`default_nettype none

package aes_ops_pkg;

	// Forward S-box.
	localparam logic [7:0] sbox [0:255] = '{
		8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
		8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
		8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
		8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
		8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
		8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
		8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
		8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
		8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
		8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
		8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
		8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
		8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
		8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
		8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
		8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
		8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
		8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
		8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
		8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
		8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
		8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
		8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
		8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
		8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
		8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
		8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
		8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
		8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
		8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
		8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
		8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
	};

	// Multiply by x in GF(2^8).
	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic aes_params_pkg::aes_state_t sub_bytes(
		input aes_params_pkg::aes_state_t s
	);
		aes_params_pkg::aes_state_t r;
		for (int i = 0; i < 16; i++) begin
			r.bytes[i] = sbox[s.bytes[i]];
		end
		return r;
	endfunction

	// Row r moves left by r columns.
	function automatic aes_params_pkg::aes_state_t shift_rows(
		input aes_params_pkg::aes_state_t s
	);
		aes_params_pkg::aes_state_t r;
		for (int c = 0; c < 4; c++) begin
			for (int row = 0; row < 4; row++) begin
				r.bytes[4*c + row] = s.bytes[4*((c + row) % 4) + row];
			end
		end
		return r;
	endfunction

	function automatic aes_params_pkg::aes_state_t mix_cols(
		input aes_params_pkg::aes_state_t s
	);
		aes_params_pkg::aes_state_t r;
		logic [7:0] a0;
		logic [7:0] a1;
		logic [7:0] a2;
		logic [7:0] a3;
		for (int c = 0; c < 4; c++) begin
			a0 = s.bytes[4*c];
			a1 = s.bytes[4*c + 1];
			a2 = s.bytes[4*c + 2];
			a3 = s.bytes[4*c + 3];
			// Matrix rows 2 3 1 1, rotated per output byte.
			r.bytes[4*c]     = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
			r.bytes[4*c + 1] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
			r.bytes[4*c + 2] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
			r.bytes[4*c + 3] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
		end
		return r;
	endfunction

	function automatic logic [31:0] rot_word(input logic [31:0] w);
		return {w[23:0], w[31:24]}; // One byte left.
	endfunction

	function automatic logic [31:0] sub_word(input logic [31:0] w);
		logic [31:0] r;
		for (int i = 0; i < 4; i++) begin
			r[8*i +: 8] = sbox[w[8*i +: 8]];
		end
		return r;
	endfunction

endpackage

`default_nettype wire

// File: logic/aes_params_pkg.sv
`default_nettype none

package aes_params_pkg;

	localparam int blk_s = 128;   // Block width in bits.
	localparam int key_s = 128;   // Key width in bits.
	localparam int nk = 4;        // Key length in 32-bit words.
	localparam int nr = 10;       // Number of rounds.
	localparam int round_w = 4;   // Holds round numbers 0 to nr.

	// Round constants for rounds 1 to 10.
	localparam logic [7:0] rcon [1:nr] = '{
		8'h01,
		8'h02,
		8'h04,
		8'h08,
		8'h10,
		8'h20,
		8'h40,
		8'h80,
		8'h1b,
		8'h36
	};

	// Cipher state as one block or as sixteen bytes.
	// Byte 0 is the most significant, bytes run down each column.
	typedef union packed {
		logic [blk_s-1:0] blk;
		logic [0:blk_s/8-1][7:0] bytes;
	} aes_state_t;

endpackage

`default_nettype wire

// File: logic/cipher.sv
`timescale 1ns/1ps
`default_nettype none

module cipher (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               start,
	input  logic [aes_params_pkg::blk_s-1:0]   plaintext,
	input  logic [aes_params_pkg::key_s-1:0]   round_key,
	input  logic [aes_params_pkg::round_w-1:0] round_no,
	input  logic                               key_valid,
	output logic [aes_params_pkg::blk_s-1:0]   ciphertext,
	output logic                               done
);
	import aes_params_pkg::*;
	import aes_ops_pkg::*;

	aes_state_t pt_q;   // Plaintext held until round 0.
	aes_state_t state;
	aes_state_t sb;
	aes_state_t sr;
	aes_state_t mc;
	aes_state_t src;
	aes_state_t nxt;
	logic first_round;
	logic final_round;

	assign first_round = (round_no == '0);
	assign final_round = (round_no == round_w'(nr));

	// Round datapath on the current state.
	always_comb begin
		sb = sub_bytes(state);
		sr = shift_rows(sb);
		mc = mix_cols(sr);
	end

	// Pick the round form, then add the round key.
	always_comb begin
		if (first_round)
			src = pt_q;
		else if (final_round)
			src = sr; // No MixColumns in the last round.
		else
			src = mc;
		nxt.blk = src.blk ^ round_key;
	end

	// Key schedule is idle exactly when key_valid is low.
	always_ff @(posedge clk) begin
		if (start && !key_valid)
			pt_q.blk <= plaintext;
	end

	always_ff @(posedge clk) begin
		if (key_valid)
			state <= nxt;
	end

	always_ff @(posedge clk) begin
		if (reset)
			done <= 1'b0;
		else
			done <= key_valid && final_round; // One cycle after round 10.
	end

	assign ciphertext = state.blk;

endmodule

`default_nettype wire

// File: logic/key_schedule.sv
`timescale 1ns/1ps
`default_nettype none

module key_schedule (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               start,
	input  logic [aes_params_pkg::key_s-1:0]   key,
	output logic [aes_params_pkg::key_s-1:0]   round_key,
	output logic [aes_params_pkg::round_w-1:0] round_no,
	output logic                               key_valid,
	output logic                               busy
);
	import aes_params_pkg::*;
	import aes_ops_pkg::*;

	logic active; // A block is in flight.
	logic load;
	logic last_round;
	logic [7:0] rc;
	logic [31:0] w [0:nk-1];
	logic [31:0] n [0:nk-1];
	logic [31:0] temp;
	logic [key_s-1:0] next_key;

	assign load = start && !active; // Start is dropped while busy.
	assign last_round = (round_no == round_w'(nr));

	// Next round key from the one on the output.
	always_comb begin
		for (int i = 0; i < nk; i++) begin
			w[i] = round_key[key_s-1-32*i -: 32];
		end
		rc = 8'h00;
		if (!last_round)
			rc = rcon[round_no + 1'b1];
		temp = sub_word(rot_word(w[nk-1])) ^ {rc, 24'h000000};
		n[0] = w[0] ^ temp;
		for (int i = 1; i < nk; i++) begin
			n[i] = w[i] ^ n[i-1];
		end
		for (int i = 0; i < nk; i++) begin
			next_key[key_s-1-32*i -: 32] = n[i];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			round_no <= '0;
		end else if (load) begin
			active <= 1'b1;
			round_no <= '0;
		end else if (active) begin
			if (last_round)
				active <= 1'b0; // Round 10 was presented.
			else
				round_no <= round_no + 1'b1;
		end
	end

	// Round 0 key is the cipher key itself.
	always_ff @(posedge clk) begin
		if (load)
			round_key <= key;
		else if (active && !last_round)
			round_key <= next_key;
	end

	assign key_valid = active;
	assign busy = active;

endmodule

`default_nettype wire
